/* rtl/synth_pkg.sv */
package synth_pkg;

    // bus widths
    localparam int WB_DW = 32;
    localparam int WB_AW = 6;

    // running status class
    typedef enum logic [2:0] {
        ST_NONE,
        ST_NOTE_OFF,
        ST_NOTE_ON,
        ST_CTRL,
        ST_OTHER
    } midi_status_e;

    // key/controller number first, velocity/value second
    typedef enum logic {
        PH_FIRST,
        PH_SECOND
    } byte_phase_e;

    // word addresses
    typedef enum logic [WB_AW-1:0] {
        ADDR_MIDI_TX      = 6'h00,
        ADDR_ACTIVE       = 6'h01,
        ADDR_KEY_ON       = 6'h02,
        ADDR_LAST_VEL_OFF = 6'h03,
        ADDR_KEY_BASE     = 6'h10,
        ADDR_VEL_BASE     = 6'h20
    } wb_addr_e;

    localparam logic [7:0] KEY_NONE         = 8'hFF;
    localparam logic [7:0] CC_ALL_NOTES_OFF = 8'd123;

endpackage

/* rtl/midi_msg_if.sv */
`timescale 1ns/1ns

interface midi_msg_if import synth_pkg::*; ();

    // one-cycle strobe per data byte
    logic         byte_valid;
    logic [7:0]   data_byte;
    midi_status_e status;
    byte_phase_e  phase;

    modport dec (
        output byte_valid,
        output data_byte,
        output status,
        output phase
    );

    modport stack (
        input byte_valid,
        input data_byte,
        input status,
        input phase
    );

endinterface

/* rtl/key_event_if.sv */
`timescale 1ns/1ns

interface key_event_if #(
    parameter int VOICES = 8
) ();

    localparam int VW = $clog2(VOICES);

    logic [VOICES-1:0]      key_on;
    logic [VOICES-1:0][7:0] key_val;
    logic [VOICES-1:0][7:0] vel_on;
    logic [7:0]             last_vel_off;
    logic [VW:0]            active_keys;
    logic                   note_on;
    // key-off marker, one pulse per released voice
    logic                   off_valid;
    logic [VW-1:0]          off_voice;

    modport stack (
        output key_on, key_val, vel_on, last_vel_off, active_keys,
        output note_on, off_valid, off_voice
    );

    modport rel (
        input key_on, off_valid, off_voice
    );

    modport regs (
        input key_on, key_val, vel_on, last_vel_off, active_keys
    );

endinterface

/* rtl/midi_status_decoder.sv */
`timescale 1ns/1ns

module midi_status_decoder import synth_pkg::*; (
    input  logic       reg_clk,
    input  logic       reset_reg_N,
    input  logic [7:0] byte_in,
    input  logic       byte_strobe,
    midi_msg_if.dec    msg
);

    midi_status_e run_status;
    byte_phase_e  cur_phase;
    midi_status_e new_status;
    logic         is_realtime;
    logic         is_status;
    logic         take_data;

    // real-time bytes may arrive even inside a message
    assign is_realtime = (byte_in >= 8'hF8);
    assign is_status   = byte_in[7];
    assign take_data   = byte_strobe && !is_status && (run_status != ST_NONE);

    // channel is omni so only the high nibble matters
    always_comb begin
        case (byte_in[7:4])
            4'h8:    new_status = ST_NOTE_OFF;
            4'h9:    new_status = ST_NOTE_ON;
            4'hB:    new_status = ST_CTRL;
            default: new_status = ST_OTHER;
        endcase
    end

    always_ff @(posedge reg_clk) begin
        if (!reset_reg_N) begin
            run_status     <= ST_NONE;
            cur_phase      <= PH_FIRST;
            msg.byte_valid <= 1'b0;
        end else begin
            msg.byte_valid <= take_data;
            if (byte_strobe && is_status && !is_realtime) begin
                // F0..F7 also land here and cancel running status
                run_status <= new_status;
                cur_phase  <= PH_FIRST;
            end else if (take_data) begin
                cur_phase <= (cur_phase == PH_FIRST) ? PH_SECOND : PH_FIRST;
            end
        end
    end

    // classified byte that goes with byte_valid
    always_ff @(posedge reg_clk) begin
        if (take_data) begin
            msg.data_byte <= byte_in;
            msg.status    <= run_status;
            msg.phase     <= cur_phase;
        end
    end

    // the note stack never sees a data byte without a status
    a_no_data_without_status: assert property (
        @(posedge reg_clk) disable iff (!reset_reg_N)
        msg.byte_valid |-> msg.status != ST_NONE
    );

endmodule

/* rtl/note_stack.sv */
`timescale 1ns/1ns

module note_stack import synth_pkg::*; #(
    parameter int VOICES = 8
) (
    input  logic              reg_clk,
    input  logic              reset_reg_N,
    midi_msg_if.stack         msg,
    input  logic [VOICES-1:0] voice_free,
    key_event_if.stack        ev
);

    localparam int VW = $clog2(VOICES);

    // key or controller number of the message in progress
    logic [7:0]    cur_note;
    // on_q oldest first, active_keys entries; off_q earliest release first
    logic [VW-1:0] on_q  [VOICES];
    logic [VW-1:0] off_q [VOICES];
    logic [VW:0]   off_cnt;

    logic          free_found;
    logic [VW-1:0] free_idx;
    logic          match_found;
    logic [VW-1:0] match_pos;
    logic [VW-1:0] match_v;
    logic [VW-1:0] alloc_v;
    logic          alloc_in_off;
    logic [VW-1:0] alloc_off_pos;

    logic          second_byte;
    logic          steal;
    logic          do_note_on;
    logic          do_note_off;
    logic          do_all_off;

    assign second_byte = msg.byte_valid && (msg.phase == PH_SECOND);
    assign steal       = (ev.active_keys == VOICES);
    assign do_note_on  = second_byte && (msg.status == ST_NOTE_ON) && (msg.data_byte != 8'd0);
    // velocity 0 on a note-on is a note-off
    assign do_note_off = second_byte && match_found &&
                         ((msg.status == ST_NOTE_OFF) ||
                          ((msg.status == ST_NOTE_ON) && (msg.data_byte == 8'd0)));
    assign do_all_off  = second_byte && (msg.status == ST_CTRL) &&
                         (cur_note == CC_ALL_NOTES_OFF);
    assign match_v     = on_q[match_pos];

    // lowest free voice
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        for (int i = VOICES - 1; i >= 0; i--) begin
            if (voice_free[i]) begin
                free_found = 1'b1;
                free_idx   = VW'(i);
            end
        end
    end

    // oldest sounding voice holding the key
    always_comb begin
        match_found = 1'b0;
        match_pos   = '0;
        for (int i = VOICES - 1; i >= 0; i--) begin
            if ((i < ev.active_keys) && (ev.key_val[on_q[i]] == cur_note)) begin
                match_found = 1'b1;
                match_pos   = VW'(i);
            end
        end
    end

    // steal oldest, else lowest free, else earliest released
    always_comb begin
        if (steal) begin
            alloc_v = on_q[0];
        end else if (free_found) begin
            alloc_v = free_idx;
        end else begin
            alloc_v = off_q[0];
        end
        alloc_in_off  = 1'b0;
        alloc_off_pos = '0;
        for (int j = VOICES - 1; j >= 0; j--) begin
            if ((j < off_cnt) && (off_q[j] == alloc_v)) begin
                alloc_in_off  = 1'b1;
                alloc_off_pos = VW'(j);
            end
        end
    end

    // queues and payload tables
    always_ff @(posedge reg_clk) begin
        if (msg.byte_valid && (msg.phase == PH_FIRST)) begin
            cur_note <= msg.data_byte;
        end
        if (do_note_on) begin
            ev.vel_on[alloc_v] <= msg.data_byte;
            if (steal) begin
                for (int i = 0; i < VOICES - 1; i++) begin
                    on_q[i] <= on_q[i+1];
                end
                on_q[VOICES-1] <= alloc_v;
            end else begin
                on_q[ev.active_keys[VW-1:0]] <= alloc_v;
                if (alloc_in_off) begin
                    for (int j = 0; j < VOICES - 1; j++) begin
                        if (j >= alloc_off_pos) begin
                            off_q[j] <= off_q[j+1];
                        end
                    end
                end
            end
        end
        if (do_note_off) begin
            for (int i = 0; i < VOICES - 1; i++) begin
                if (i >= match_pos) begin
                    on_q[i] <= on_q[i+1];
                end
            end
            off_q[off_cnt[VW-1:0]] <= match_v;
            ev.off_voice           <= match_v;
        end
    end

    always_ff @(posedge reg_clk) begin
        if (!reset_reg_N) begin
            ev.key_on       <= '0;
            ev.key_val      <= {VOICES{KEY_NONE}};
            ev.active_keys  <= '0;
            ev.last_vel_off <= '0;
            ev.note_on      <= 1'b0;
            ev.off_valid    <= 1'b0;
            off_cnt         <= '0;
        end else begin
            ev.note_on   <= 1'b0;
            ev.off_valid <= 1'b0;
            if (do_note_on) begin
                ev.key_on[alloc_v]  <= 1'b1;
                ev.key_val[alloc_v] <= cur_note;
                ev.note_on          <= 1'b1;
                if (!steal) begin
                    ev.active_keys <= ev.active_keys + 1'b1;
                    if (alloc_in_off) begin
                        off_cnt <= off_cnt - 1'b1;
                    end
                end
            end else if (do_note_off) begin
                ev.key_on[match_v]  <= 1'b0;
                ev.key_val[match_v] <= KEY_NONE;
                ev.active_keys      <= ev.active_keys - 1'b1;
                ev.off_valid        <= 1'b1;
                off_cnt             <= off_cnt + 1'b1;
                if (msg.status == ST_NOTE_OFF) begin
                    ev.last_vel_off <= msg.data_byte;
                end
            end else if (do_all_off) begin
                // voices drop straight to free, no release pass
                ev.key_on      <= '0;
                ev.key_val     <= {VOICES{KEY_NONE}};
                ev.active_keys <= '0;
            end
        end
    end

    a_active_bound: assert property (
        @(posedge reg_clk) disable iff (!reset_reg_N)
        ev.active_keys <= VOICES
    );

    a_active_matches_bitmap: assert property (
        @(posedge reg_clk) disable iff (!reset_reg_N)
        $countones(ev.key_on) == ev.active_keys
    );

endmodule

/* rtl/voice_release.sv */
`timescale 1ns/1ns

module voice_release #(
    parameter int VOICES         = 8,
    parameter int RELEASE_CYCLES = 64
) (
    input  logic              reg_clk,
    input  logic              reset_reg_N,
    key_event_if.rel          ev,
    output logic [VOICES-1:0] voice_free
);

    localparam int            VW   = $clog2(VOICES);
    localparam int            CW   = $clog2(RELEASE_CYCLES + 1);
    // counter reaches zero RELEASE_CYCLES after the off pulse
    localparam logic [CW-1:0] LOAD = CW'(RELEASE_CYCLES - 1);

    for (genvar v = 0; v < VOICES; v++) begin : g_voice
        logic [CW-1:0] cnt;
        logic          off_hit;

        assign off_hit = ev.off_valid && (ev.off_voice == VW'(v));

        always_ff @(posedge reg_clk) begin
            if (!reset_reg_N) begin
                cnt <= '0;
            end else if (off_hit) begin
                cnt <= LOAD;
            end else if (ev.key_on[v]) begin
                // re-keyed during release
                cnt <= '0;
            end else if (cnt != '0) begin
                cnt <= cnt - 1'b1;
            end
        end

        // off_hit masks the cycle before the counter loads
        assign voice_free[v] = !ev.key_on[v] && !off_hit && (cnt == '0);

        // a key dropped by a note-off is not free at once
        a_no_free_on_key_drop: assert property (
            @(posedge reg_clk) disable iff (!reset_reg_N)
            $fell(ev.key_on[v]) |-> !voice_free[v] || (ev.key_on == '0)
        );
    end

endmodule

/* rtl/synth_wb_regs.sv */
`timescale 1ns/1ns

module synth_wb_regs import synth_pkg::*; #(
    parameter int VOICES = 8
) (
    input  logic             reg_clk,
    input  logic             reset_reg_N,
    input  logic             wb_cyc,
    input  logic             wb_stb,
    input  logic             wb_we,
    input  logic [WB_AW-1:0] wb_adr,
    input  logic [WB_DW-1:0] wb_dat_w,
    input  logic [3:0]       wb_sel,
    output logic [WB_DW-1:0] wb_dat_r,
    output logic             wb_ack,
    output logic [7:0]       byte_out,
    output logic             byte_strobe,
    key_event_if.regs        ev
);

    localparam int             VW       = $clog2(VOICES);
    localparam logic [WB_AW-1:0] TBL_MASK = 6'h30;

    logic             req;
    logic             ack_done;
    logic             ack_next;
    logic             tbl_hit;
    logic [VW-1:0]    tbl_idx;
    logic [WB_DW-1:0] rd_data;

    assign req      = wb_cyc && wb_stb;
    // one ack per strobe, then wait for stb to drop
    assign ack_next = req && !wb_ack && !ack_done;
    assign tbl_hit  = (wb_adr[3:0] < VOICES);
    assign tbl_idx  = wb_adr[VW-1:0];

    always_comb begin
        rd_data = '0;
        if (wb_adr == ADDR_ACTIVE) begin
            rd_data[VW:0] = ev.active_keys;
        end else if (wb_adr == ADDR_KEY_ON) begin
            rd_data[VOICES-1:0] = ev.key_on;
        end else if (wb_adr == ADDR_LAST_VEL_OFF) begin
            rd_data[7:0] = ev.last_vel_off;
        end else if (((wb_adr & TBL_MASK) == ADDR_KEY_BASE) && tbl_hit) begin
            rd_data[7:0] = ev.key_val[tbl_idx];
        end else if (((wb_adr & TBL_MASK) == ADDR_VEL_BASE) && tbl_hit) begin
            rd_data[7:0] = ev.vel_on[tbl_idx];
        end
    end

    always_ff @(posedge reg_clk) begin
        if (!reset_reg_N) begin
            wb_ack      <= 1'b0;
            ack_done    <= 1'b0;
            byte_strobe <= 1'b0;
        end else begin
            wb_ack      <= ack_next;
            ack_done    <= req && (ack_done || wb_ack);
            byte_strobe <= ack_next && wb_we && (wb_adr == ADDR_MIDI_TX) && wb_sel[0];
        end
    end

    always_ff @(posedge reg_clk) begin
        if (ack_next) begin
            wb_dat_r <= rd_data;
            byte_out <= wb_dat_w[7:0];
        end
    end

    // master must hold the request until acked
    a_ack_in_cycle: assert property (
        @(posedge reg_clk) disable iff (!reset_reg_N)
        wb_ack |-> wb_cyc && wb_stb
    );

endmodule

/* rtl/synth_voice_ctrl.sv */
`timescale 1ns/1ns

module synth_voice_ctrl import synth_pkg::*; #(
    parameter int VOICES         = 8,
    parameter int RELEASE_CYCLES = 64
) (
    input  logic              reg_clk,
    input  logic              reset_reg_N,
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  logic [WB_AW-1:0]  wb_adr,
    input  logic [WB_DW-1:0]  wb_dat_w,
    input  logic [3:0]        wb_sel,
    output logic [WB_DW-1:0]  wb_dat_r,
    output logic              wb_ack,
    output logic [VOICES-1:0] key_on,
    output logic              note_on_pulse
);

    logic [7:0]        midi_byte;
    logic              midi_strobe;
    logic [VOICES-1:0] voice_free;

    midi_msg_if                      msg_bus ();
    key_event_if #(.VOICES(VOICES))  key_bus ();

    assign key_on        = key_bus.key_on;
    assign note_on_pulse = key_bus.note_on;

    synth_wb_regs #(.VOICES(VOICES)) u_regs (
        .reg_clk(reg_clk), .reset_reg_N(reset_reg_N),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .byte_out(midi_byte), .byte_strobe(midi_strobe), .ev(key_bus.regs)
    );

    midi_status_decoder u_dec (
        .reg_clk(reg_clk), .reset_reg_N(reset_reg_N),
        .byte_in(midi_byte), .byte_strobe(midi_strobe), .msg(msg_bus.dec)
    );

    note_stack #(.VOICES(VOICES)) u_stack (
        .reg_clk(reg_clk), .reset_reg_N(reset_reg_N),
        .msg(msg_bus.stack), .voice_free(voice_free), .ev(key_bus.stack)
    );

    voice_release #(.VOICES(VOICES), .RELEASE_CYCLES(RELEASE_CYCLES)) u_rel (
        .reg_clk(reg_clk), .reset_reg_N(reset_reg_N),
        .ev(key_bus.rel), .voice_free(voice_free)
    );

endmodule

/* tb/tb_synth_voice_ctrl.sv */
`timescale 1ns/1ns

module tb_synth_voice_ctrl import synth_pkg::*; ();

    localparam int VOICES         = 4;
    localparam int RELEASE_CYCLES = 16;
    localparam int ACK_TIMEOUT    = 20;

    logic              reg_clk;
    logic              reset_reg_N;
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    logic [WB_AW-1:0]  wb_adr;
    logic [WB_DW-1:0]  wb_dat_w;
    logic [3:0]        wb_sel;
    logic [WB_DW-1:0]  wb_dat_r;
    logic              wb_ack;
    logic [VOICES-1:0] key_on;
    logic              note_on_pulse;

    // reference voice model
    logic [7:0]        m_key [VOICES];
    logic [7:0]        m_vel [VOICES];
    logic [VOICES-1:0] m_on;
    logic [VOICES-1:0] m_rel;
    logic [7:0]        m_last_off;
    int                m_onq[$];
    int                m_offq[$];
    int                m_note_ons;

    logic [15:0]       lfsr;
    int                pulse_count;
    int                checks;
    int                errors;
    int                tests_run;

    synth_voice_ctrl #(.VOICES(VOICES), .RELEASE_CYCLES(RELEASE_CYCLES)) uut (
        .reg_clk(reg_clk), .reset_reg_N(reset_reg_N),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .key_on(key_on), .note_on_pulse(note_on_pulse)
    );

    always #20 reg_clk = ~reg_clk;

    always @(negedge reg_clk) begin
        if (note_on_pulse === 1'b1) begin
            pulse_count++;
        end
    end

    // galois lfsr, one step per bit taken
    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[6:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic logic [7:0] random_velocity();
        logic [7:0] v;
        v = rand_bits(7);
        return (v == 8'd0) ? 8'd1 : v;
    endfunction

    function automatic int model_note_on(input logic [7:0] key, input logic [7:0] vel);
        int v;
        v = -1;
        if (m_onq.size() == VOICES) begin
            // every voice sounding, oldest note loses its voice
            v = m_onq.pop_front();
        end else begin
            for (int i = VOICES - 1; i >= 0; i--) begin
                if (!m_on[i] && !m_rel[i]) begin
                    v = i;
                end
            end
            if (v < 0) begin
                v = m_offq[0];
            end
            for (int i = 0; i < m_offq.size(); i++) begin
                if (m_offq[i] == v) begin
                    m_offq.delete(i);
                    break;
                end
            end
        end
        m_onq.push_back(v);
        m_on[v]  = 1'b1;
        m_rel[v] = 1'b0;
        m_key[v] = key;
        m_vel[v] = vel;
        m_note_ons++;
        return v;
    endfunction

    // oldest sounding voice with this key is released
    function automatic void model_note_off(input logic [7:0] key, input logic [7:0] vel,
                                           input logic is_off_status);
        int pos;
        int v;
        pos = -1;
        for (int i = m_onq.size() - 1; i >= 0; i--) begin
            if (m_key[m_onq[i]] == key) begin
                pos = i;
            end
        end
        if (pos >= 0) begin
            v = m_onq[pos];
            m_onq.delete(pos);
            m_offq.push_back(v);
            m_on[v]  = 1'b0;
            m_rel[v] = 1'b1;
            m_key[v] = KEY_NONE;
            if (is_off_status) begin
                m_last_off = vel;
            end
        end
    endfunction

    function automatic void model_all_off();
        m_on = '0;
        m_onq.delete();
        for (int v = 0; v < VOICES; v++) begin
            m_key[v] = KEY_NONE;
        end
    endfunction

    task automatic check_eq(input string test, input string what,
                            input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("Fail %s %s: expected %0h, actual %0h", test, what, exp, act);
            errors++;
        end
    endtask

    task automatic bus_cycle(input logic we, input logic [WB_AW-1:0] adr,
                             input logic [WB_DW-1:0] wdata,
                             output logic [WB_DW-1:0] rdata);
        int n;
        @(posedge reg_clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdata;
        wb_sel   <= we ? 4'h1 : 4'hF;
        n = 0;
        do begin
            @(negedge reg_clk);
            n++;
        end while (!wb_ack && n < ACK_TIMEOUT);
        if (!wb_ack) begin
            $display("no wb_ack within %0d cycles at address %0h", ACK_TIMEOUT, adr);
            $display("Simulation failed");
            $finish;
        end else begin
            rdata = wb_dat_r;
            @(posedge reg_clk);
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_we  <= 1'b0;
        end
    endtask

    task automatic wb_write(input logic [WB_AW-1:0] adr, input logic [WB_DW-1:0] data);
        logic [WB_DW-1:0] unused;
        bus_cycle(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input logic [WB_AW-1:0] adr, output logic [WB_DW-1:0] data);
        bus_cycle(1'b0, adr, '0, data);
    endtask

    task automatic send_midi(input logic [7:0] b);
        wb_write(ADDR_MIDI_TX, {24'h0, b});
        repeat (2) @(posedge reg_clk);
    endtask

    // long enough for every release countdown to run out
    task automatic settle_releases();
        repeat (RELEASE_CYCLES + 4) @(posedge reg_clk);
        m_rel = '0;
    endtask

    task automatic check_table(input string test);
        logic [WB_DW-1:0] rd;
        for (int v = 0; v < VOICES; v++) begin
            wb_read(6'(ADDR_KEY_BASE + v), rd);
            check_eq(test, $sformatf("key[%0d]", v), m_key[v], rd);
            if (m_on[v]) begin
                wb_read(6'(ADDR_VEL_BASE + v), rd);
                check_eq(test, $sformatf("vel[%0d]", v), m_vel[v], rd);
            end
        end
        wb_read(ADDR_KEY_ON, rd);
        check_eq(test, "key_on register", m_on, rd);
        check_eq(test, "key_on port", m_on, key_on);
        wb_read(ADDR_ACTIVE, rd);
        check_eq(test, "active count", m_onq.size(), rd);
        wb_read(ADDR_LAST_VEL_OFF, rd);
        check_eq(test, "last off velocity", m_last_off, rd);
        check_eq(test, "note_on pulses", m_note_ons, pulse_count);
    endtask

    task automatic report_test(input string test, input int err0);
        tests_run++;
        $display("%s finished with %0d errors", test, errors - err0);
    endtask

    task automatic note_on_then_off();
        logic [7:0] key;
        logic [7:0] vel;
        logic [7:0] off_vel;
        int         err0;
        err0    = errors;
        key     = rand_bits(7);
        vel     = random_velocity();
        off_vel = rand_bits(7);
        send_midi(8'h90);
        send_midi(key);
        send_midi(vel);
        void'(model_note_on(key, vel));
        check_table("note_on_then_off");
        send_midi(8'h80);
        send_midi(key);
        send_midi(off_vel);
        model_note_off(key, off_vel, 1'b1);
        check_table("note_on_then_off");
        settle_releases();
        report_test("note_on_then_off", err0);
    endtask

    task automatic running_status_pairs();
        logic [7:0] key;
        logic [7:0] vel;
        int         err0;
        err0 = errors;
        send_midi(8'h90);
        for (int i = 0; i < 3; i++) begin
            key = rand_bits(7);
            vel = random_velocity();
            send_midi(key);
            // timing clock byte in the middle of a pair
            if (i == 1) begin
                send_midi(8'hF8);
            end
            send_midi(vel);
            void'(model_note_on(key, vel));
        end
        check_eq("running_status_pairs", "voices 0 to 2 on", 32'h7, key_on);
        check_table("running_status_pairs");
        report_test("running_status_pairs", err0);
    endtask

    task automatic zero_velocity_release();
        logic [7:0] key;
        logic [7:0] vel;
        int         err0;
        err0 = errors;
        key  = m_key[1];
        send_midi(key);
        send_midi(8'h00);
        model_note_off(key, 8'h00, 1'b0);
        check_table("zero_velocity_release");
        settle_releases();
        key = rand_bits(7);
        vel = random_velocity();
        send_midi(key);
        send_midi(vel);
        void'(model_note_on(key, vel));
        check_table("zero_velocity_release");
        report_test("zero_velocity_release", err0);
    endtask

    task automatic oldest_note_steal();
        logic [7:0]       key;
        logic [7:0]       vel;
        logic [WB_DW-1:0] rd;
        int               oldest;
        int               err0;
        err0 = errors;
        for (int i = 0; i < 5; i++) begin
            key    = rand_bits(7);
            vel    = random_velocity();
            oldest = m_onq[0];
            send_midi(key);
            send_midi(vel);
            void'(model_note_on(key, vel));
            check_table("oldest_note_steal");
        end
        wb_read(6'(ADDR_KEY_BASE + oldest), rd);
        check_eq("oldest_note_steal", "key in stolen voice", key, rd);
        wb_read(ADDR_ACTIVE, rd);
        check_eq("oldest_note_steal", "active after steal", VOICES, rd);
        report_test("oldest_note_steal", err0);
    endtask

    task automatic release_order_reuse();
        logic [7:0]       key_a;
        logic [7:0]       key_b;
        logic [7:0]       key;
        logic [7:0]       vel;
        logic [WB_DW-1:0] rd;
        int               first_v;
        int               err0;
        err0  = errors;
        key_a = m_key[m_onq[1]];
        key_b = m_key[m_onq[3]];
        key   = rand_bits(7);
        vel   = random_velocity();
        // back to back, so both voices are still releasing at the note-on
        wb_write(ADDR_MIDI_TX, {24'h0, key_a});
        wb_write(ADDR_MIDI_TX, 32'h0);
        wb_write(ADDR_MIDI_TX, {24'h0, key_b});
        wb_write(ADDR_MIDI_TX, 32'h0);
        wb_write(ADDR_MIDI_TX, {24'h0, key});
        wb_write(ADDR_MIDI_TX, {24'h0, vel});
        model_note_off(key_a, 8'h00, 1'b0);
        first_v = m_offq[m_offq.size() - 1];
        model_note_off(key_b, 8'h00, 1'b0);
        void'(model_note_on(key, vel));
        repeat (2) @(posedge reg_clk);
        wb_read(6'(ADDR_KEY_BASE + first_v), rd);
        check_eq("release_order_reuse", "key in first released voice", key, rd);
        check_table("release_order_reuse");
        settle_releases();
        report_test("release_order_reuse", err0);
    endtask

    task automatic all_notes_off_cc();
        int err0;
        err0 = errors;
        // volume controller, no effect on the voices
        send_midi(8'hB0);
        send_midi(8'd7);
        send_midi(8'd100);
        check_table("all_notes_off_cc");
        send_midi(CC_ALL_NOTES_OFF);
        send_midi(8'd0);
        model_all_off();
        check_eq("all_notes_off_cc", "key_on after cc 123", 32'h0, key_on);
        check_table("all_notes_off_cc");
        report_test("all_notes_off_cc", err0);
    endtask

    initial begin
        reg_clk     = 1'b0;
        reset_reg_N = 1'b0;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_dat_w    = '0;
        wb_sel      = 4'h0;
        lfsr        = 16'd16369;
        m_on        = '0;
        m_rel       = '0;
        m_last_off  = 8'h00;
        m_note_ons  = 0;
        for (int v = 0; v < VOICES; v++) begin
            m_key[v] = KEY_NONE;
            m_vel[v] = 8'h00;
        end
        repeat (2) @(posedge reg_clk);
        reset_reg_N <= 1'b1;

        note_on_then_off();
        running_status_pairs();
        zero_velocity_release();
        oldest_note_steal();
        release_order_reuse();
        all_notes_off_cc();

        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* sources.f */
rtl/synth_pkg.sv
rtl/midi_msg_if.sv
rtl/key_event_if.sv
rtl/midi_status_decoder.sv
rtl/note_stack.sv
rtl/voice_release.sv
rtl/synth_wb_regs.sv
rtl/synth_voice_ctrl.sv
tb/tb_synth_voice_ctrl.sv
